/* hdl/fdc_pkg.sv */
// fdc package: widths, status bits, result codes, sequencer states, port structs
`default_nettype none

package fdc_pkg;

	typedef logic [7:0] fdc_byte_t;  // host data byte
	typedef logic [7:0] cyl_t;       // cylinder number
	typedef logic [3:0] step_rate_t; // SPECIFY srt field
	typedef logic       drive_t;     // drive select

	// ==========================================================
	// main status register bit positions
	// ==========================================================
	localparam int MSR_D0B = 0;
	localparam int MSR_D1B = 1;
	localparam int MSR_CB  = 4;
	localparam int MSR_DIO = 6;
	localparam int MSR_RQM = 7;

	// result bytes, seek codes get the drive number ORed in
	localparam fdc_byte_t ST0_SEEK_OK  = 8'h20;
	localparam fdc_byte_t ST0_SEEK_ERR = 8'he8;
	localparam fdc_byte_t ST0_INVALID  = 8'h80; // also "no interrupt pending"
	localparam fdc_byte_t IDLE_READ    = 8'hff;

	typedef enum logic [3:0] {
		IDLE, SPECIFY1, SPECIFY2, RECAL1, SEEK1, SEEK2,
		SENSE_INT1, SENSE_INT2, SENSE_DRV1, SENSE_DRV_RD, INVALID_RD
	} fdc_state_t;

	// host port to sequencer, strobes already qualified by a0
	typedef struct packed {
		logic      rd_stb;
		logic      wr_stb;
		fdc_byte_t data;
	} host_req_t;

	typedef struct packed {
		logic       start;   // load target as new cylinder
		logic       clr_int;
		logic       ack_int; // interrupt reported by SENSE INTERRUPT
		step_rate_t srt;
		cyl_t       target;
	} seek_cmd_t;

	typedef struct packed {
		cyl_t pcn;
		logic busy;
		logic int_pend;
		logic seek_ok;
	} drive_stat_t;

endpackage

`default_nettype wire

/* hdl/fdc_host_port.sv */
// host register port: read/write edge strobes and output data mux
`timescale 1ns/1ps
`default_nettype none

module fdc_host_port
	import fdc_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire            i_nrd,
	input  wire            i_nwr,
	input  wire            i_a0,
	input  wire fdc_byte_t i_din,
	input  wire fdc_byte_t i_msr,
	input  wire fdc_byte_t i_data_reg,
	output host_req_t      o_req,
	output fdc_byte_t      o_dout
);

	logic      rd_lvl, wr_lvl;
	logic      old_rd, old_wr;
	logic      rd_stb, wr_stb;
	fdc_byte_t din_q;

	assign rd_lvl = i_nwr & ~i_nrd;
	assign wr_lvl = ~i_nwr & i_nrd;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_rd <= 1'b0;
			old_wr <= 1'b0;
			rd_stb <= 1'b0;
			wr_stb <= 1'b0;
		end else begin
			old_rd <= rd_lvl;
			old_wr <= wr_lvl;
			rd_stb <= rd_lvl & ~old_rd & i_a0; // one pulse per falling level
			wr_stb <= wr_lvl & ~old_wr & i_a0;
		end
		din_q <= i_din; // host holds din while nwr is low
	end

	assign o_req  = '{rd_stb: rd_stb, wr_stb: wr_stb, data: din_q};
	assign o_dout = i_a0 ? i_data_reg : i_msr;

endmodule

`default_nettype wire

/* hdl/fdc_cmd_seq.sv */
// command sequencer: decode, parameter collection, replies, main status and data registers
`timescale 1ns/1ps
`default_nettype none

module fdc_cmd_seq
	import fdc_pkg::*;
(
	input  wire              clk_sys,
	input  wire              reset,
	input  wire host_req_t   i_req,
	input  wire drive_stat_t i_stat0,
	input  wire drive_stat_t i_stat1,
	input  wire [1:0]        i_ready,
	input  wire [1:0]        i_wp,
	output seek_cmd_t        o_seek0,
	output seek_cmd_t        o_seek1,
	output fdc_byte_t        o_msr,
	output fdc_byte_t        o_data_reg
);

	fdc_state_t  state;
	fdc_state_t  cmd_state; // decoded first byte
	step_rate_t  srt;
	drive_t      ds;
	drive_t      int_drv;
	logic        head;
	cyl_t        target;
	logic [1:0]  start_q, clr_q, ack_q;
	fdc_byte_t   msr, data_reg;
	fdc_byte_t   st0_reply, drv_status;
	drive_stat_t stat [2];
	logic        reply_pending;

	assign stat[0] = i_stat0;
	assign stat[1] = i_stat1;

	// only the low five bits select the command
	always_comb begin
		case (i_req.data[4:0])
			5'h03:   cmd_state = SPECIFY1;
			5'h07:   cmd_state = RECAL1;
			5'h0f:   cmd_state = SEEK1;
			5'h08:   cmd_state = SENSE_INT1;
			5'h04:   cmd_state = SENSE_DRV1;
			default: cmd_state = INVALID_RD;
		endcase
	end

	// drive 0 wins when both have an interrupt pending
	assign int_drv   = ~stat[0].int_pend;
	assign st0_reply = (stat[int_drv].seek_ok ? ST0_SEEK_OK : ST0_SEEK_ERR) |
		fdc_byte_t'(int_drv);

	// st3: wp, ready, track 0, single sided, head, drive
	assign drv_status = {1'b0, i_ready[ds] & i_wp[ds], i_ready[ds],
		stat[ds].pcn == '0, 1'b0, head, 1'b0, ds};

	// ==========================================================
	// command phase FSM
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= IDLE;
			srt     <= 4'd4;
			start_q <= '0;
			clr_q   <= '0;
			ack_q   <= '0;
		end else begin
			start_q <= '0; // strobes last one cycle
			clr_q   <= '0;
			ack_q   <= '0;

			case (state)
				IDLE:
				if (i_req.wr_stb) begin
					state <= cmd_state;
					if (cmd_state == SPECIFY1 || cmd_state == SENSE_DRV1 ||
						cmd_state == INVALID_RD)
						clr_q <= 2'b11;
				end else if (i_req.rd_stb) begin
					data_reg <= IDLE_READ;
				end

				SPECIFY1:
				if (i_req.wr_stb) begin
					srt   <= i_req.data[7:4]; // hut in low nibble unused
					state <= SPECIFY2;
				end

				SPECIFY2: if (i_req.wr_stb) state <= IDLE; // head load time ignored

				RECAL1:
				if (i_req.wr_stb) begin
					ds                  <= i_req.data[0];
					target              <= '0;
					start_q[i_req.data[0]] <= 1'b1;
					state               <= IDLE;
				end

				SEEK1:
				if (i_req.wr_stb) begin
					ds                   <= i_req.data[0];
					clr_q[i_req.data[0]] <= 1'b1;
					state                <= SEEK2;
				end

				SEEK2:
				if (i_req.wr_stb) begin
					target      <= i_req.data;
					start_q[ds] <= 1'b1;
					state       <= IDLE;
				end

				SENSE_INT1:
				if (i_req.rd_stb) begin
					if (stat[0].int_pend || stat[1].int_pend) begin
						ds       <= int_drv;
						data_reg <= st0_reply;
						state    <= SENSE_INT2;
					end else begin
						data_reg <= ST0_INVALID;
						state    <= IDLE;
					end
				end

				SENSE_INT2:
				if (i_req.rd_stb) begin
					data_reg  <= stat[ds].pcn;
					ack_q[ds] <= 1'b1;
					state     <= IDLE;
				end

				SENSE_DRV1:
				if (i_req.wr_stb) begin
					ds    <= i_req.data[0];
					head  <= i_req.data[2];
					state <= SENSE_DRV_RD;
				end

				SENSE_DRV_RD:
				if (i_req.rd_stb) begin
					data_reg <= drv_status;
					state    <= IDLE;
				end

				INVALID_RD:
				if (i_req.rd_stb) begin
					data_reg <= ST0_INVALID;
					state    <= IDLE;
				end

				default: state <= IDLE;
			endcase
		end
	end

	assign reply_pending = (state == SENSE_INT1) || (state == SENSE_INT2) ||
		(state == SENSE_DRV_RD) || (state == INVALID_RD);

	// main status, one cycle behind the events
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			msr <= 8'h80;
		end else begin
			msr          <= '0;
			msr[MSR_RQM] <= 1'b1;
			msr[MSR_DIO] <= reply_pending;
			msr[MSR_CB]  <= state != IDLE;
			msr[MSR_D0B] <= stat[0].busy;
			msr[MSR_D1B] <= stat[1].busy;
		end
	end

	assign o_seek0 = '{start: start_q[0], clr_int: clr_q[0], ack_int: ack_q[0],
		srt: srt, target: target};
	assign o_seek1 = '{start: start_q[1], clr_int: clr_q[1], ack_int: ack_q[1],
		srt: srt, target: target};

	assign o_msr      = msr;
	assign o_data_reg = data_reg;

endmodule

`default_nettype wire

/* hdl/fdc_head_stepper.sv */
// head stepper for one drive: cylinder registers, step timer, seek check, interrupt flag
`timescale 1ns/1ps
`default_nettype none

module fdc_head_stepper
	import fdc_pkg::*;
#(
	parameter int CYCLES  = 4000, // clocks per ms
	parameter int MAX_CYL = 80
) (
	input  wire            clk_sys,
	input  wire            reset,
	input  wire seek_cmd_t i_cmd,
	input  wire            i_motor,
	input  wire            i_ready,
	input  wire            i_fast,
	output drive_stat_t    o_stat
);

	localparam int TW = $clog2(CYCLES + 1);

	typedef enum logic [1:0] {IDLE, COMPARE, STEP_WAIT} step_state_t;

	step_state_t   state;
	cyl_t          pcn, ncn;
	logic          int_pend, seek_ok;
	step_rate_t    step_cnt;   // counts up from srt to 15
	logic [TW-1:0] step_timer;
	logic          target_ok;

	// track 0 is always reachable
	assign target_ok = (i_cmd.target == '0) ||
		(i_motor && i_ready && (int'(i_cmd.target) < MAX_CYL));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= IDLE;
			pcn      <= '0;
			ncn      <= '0;
			int_pend <= 1'b0;
			seek_ok  <= 1'b0;
		end else begin
			if (i_cmd.clr_int || i_cmd.ack_int)
				int_pend <= 1'b0;

			case (state)
				IDLE: ;
				COMPARE:
				if (pcn == ncn) begin
					int_pend <= 1'b1;
					seek_ok  <= i_ready;
					state    <= IDLE;
				end else if (i_fast) begin
					pcn <= ncn; // jump, matched on next compare
				end else begin
					pcn        <= (pcn > ncn) ? pcn - 1'b1 : pcn + 1'b1;
					step_cnt   <= i_cmd.srt;
					step_timer <= TW'(CYCLES - 1); // compare cycle counts too
					state      <= STEP_WAIT;
				end

				STEP_WAIT:
				if (step_timer != '0) begin
					step_timer <= step_timer - 1'b1;
				end else if (step_cnt != 4'hf) begin
					step_cnt   <= step_cnt + 1'b1;
					step_timer <= TW'(CYCLES);
				end else begin
					state <= COMPARE;
				end

				default: state <= IDLE;
			endcase

			// new seek overrides whatever is in progress
			if (i_cmd.start) begin
				if (target_ok) begin
					ncn      <= i_cmd.target;
					int_pend <= 1'b0;
					state    <= COMPARE;
				end else begin
					int_pend <= 1'b1; // seek error, head stays put
					seek_ok  <= 1'b0;
					state    <= IDLE;
				end
			end
		end
	end

	assign o_stat = '{pcn: pcn, busy: state != IDLE, int_pend: int_pend, seek_ok: seek_ok};

endmodule

`default_nettype wire

/* hdl/fdc_top.sv */
// fdc top level: host port, command sequencer and two head steppers
`timescale 1ns/1ps
`default_nettype none

module fdc_top
	import fdc_pkg::*;
#(
	parameter int CYCLES  = 4000,
	parameter int MAX_CYL = 80
) (
	input  wire            clk_sys,
	input  wire            reset,
	input  wire            i_nrd,
	input  wire            i_nwr,
	input  wire            i_a0,
	input  wire            i_fast,  // immediate seek
	input  wire fdc_byte_t i_din,
	input  wire [1:0]      i_motor,
	input  wire [1:0]      i_ready, // media present
	input  wire [1:0]      i_wp,
	output fdc_byte_t      o_dout
);

	host_req_t   req;
	seek_cmd_t   seek0, seek1;
	drive_stat_t stat0, stat1;
	fdc_byte_t   msr, data_reg;

	fdc_host_port u_host (
		.clk_sys(clk_sys), .reset(reset),
		.i_nrd(i_nrd), .i_nwr(i_nwr), .i_a0(i_a0), .i_din(i_din),
		.i_msr(msr), .i_data_reg(data_reg),
		.o_req(req), .o_dout(o_dout)
	);

	fdc_cmd_seq u_seq (
		.clk_sys(clk_sys), .reset(reset), .i_req(req),
		.i_stat0(stat0), .i_stat1(stat1), .i_ready(i_ready), .i_wp(i_wp),
		.o_seek0(seek0), .o_seek1(seek1), .o_msr(msr), .o_data_reg(data_reg)
	);

	// ==========================================================
	// one stepper per drive
	// ==========================================================
	fdc_head_stepper #(.CYCLES(CYCLES), .MAX_CYL(MAX_CYL)) u_step0 (
		.clk_sys(clk_sys), .reset(reset), .i_cmd(seek0),
		.i_motor(i_motor[0]), .i_ready(i_ready[0]), .i_fast(i_fast), .o_stat(stat0)
	);

	fdc_head_stepper #(.CYCLES(CYCLES), .MAX_CYL(MAX_CYL)) u_step1 (
		.clk_sys(clk_sys), .reset(reset), .i_cmd(seek1),
		.i_motor(i_motor[1]), .i_ready(i_ready[1]), .i_fast(i_fast), .o_stat(stat1)
	);

endmodule

`default_nettype wire

/* tests/fdc_sva.sv */
// stepper assertions: single-cylinder steps, busy/interrupt exclusion, seek completion
`timescale 1ns/1ps
`default_nettype none

module fdc_sva
	import fdc_pkg::*;
(
	input wire              clk_sys,
	input wire              reset,
	input wire              i_fast,
	input wire seek_cmd_t   i_cmd,
	input wire drive_stat_t i_stat
);

	cyl_t last_target; // target of the most recent start

	always_ff @(posedge clk_sys) begin
		if (reset)
			last_target <= '0;
		else if (i_cmd.start)
			last_target <= i_cmd.target;
	end

	// slow mode moves the head one cylinder at a time
	a_single_step: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(i_fast) |-> (i_stat.pcn == $past(i_stat.pcn) ||
		i_stat.pcn == $past(i_stat.pcn) + 8'd1 || i_stat.pcn == $past(i_stat.pcn) - 8'd1))
		else $error("pcn moved by more than one cylinder in one cycle");

	a_busy_xor_int: assert property (@(posedge clk_sys) disable iff (reset)
		!(i_stat.busy && i_stat.int_pend))
		else $error("busy and int_pend set together");

	a_seek_done: assert property (@(posedge clk_sys) disable iff (reset)
		($fell(i_stat.busy) && !$past(i_cmd.start)) |-> i_stat.pcn == last_target) // no override
		else $error("busy fell before pcn reached the target");

endmodule

bind fdc_head_stepper fdc_sva u_sva (
	.clk_sys(clk_sys), .reset(reset), .i_fast(i_fast),
	.i_cmd(i_cmd), .i_stat(o_stat)
);

`default_nettype wire

/* tests/fdc_tb.sv */
// fdc testbench: clock, reset, host access tasks, directed tests and timeout
`timescale 1ns/1ps
`default_nettype none

module fdc_tb
	import fdc_pkg::*;
();

	localparam int CYCLES  = 4;
	localparam int MAX_CYL = 40;
	localparam int TIMEOUT = 40 * 16 * 5 * 6 + 2000; // longest seeks plus host traffic

	logic       clk_sys, reset, nrd, nwr, a0, fast;
	logic [1:0] motor, ready, wp;
	fdc_byte_t  din, dout;
	integer     seed, cycle_cnt;
	cyl_t       cyl0, cyl1; // expected head positions

	fdc_top #(.CYCLES(CYCLES), .MAX_CYL(MAX_CYL)) DUT (
		.clk_sys(clk_sys), .reset(reset), .i_nrd(nrd), .i_nwr(nwr), .i_a0(a0),
		.i_fast(fast), .i_din(din), .i_motor(motor), .i_ready(ready), .i_wp(wp),
		.o_dout(dout)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT)
			fail_run("timeout: the tests did not finish within the cycle limit");
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input fdc_byte_t got, input fdc_byte_t exp, input string what);
		assert (got == exp) else
			fail_run($sformatf("FAILED at %0t: %s read %02h, expected %02h",
				$time, what, got, exp));
	endtask

	// ==========================================================
	// host bus access, levels held 3 cycles low and 3 high
	// ==========================================================
	task automatic host_write(input fdc_byte_t data);
		@(posedge clk_sys);
		a0  <= 1'b1;
		din <= data;
		nwr <= 1'b0;
		repeat (3) @(posedge clk_sys);
		nwr <= 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic host_read(input logic addr, output fdc_byte_t data);
		@(posedge clk_sys);
		a0  <= addr;
		nrd <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys) data = dout; // third cycle of the low level
		@(posedge clk_sys);
		nrd <= 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic set_lines(input logic [1:0] m, input logic [1:0] r, input logic [1:0] w,
		input logic f);
		@(posedge clk_sys);
		motor <= m;
		ready <= r;
		wp    <= w;
		fast  <= f;
	endtask

	task automatic seek(input drive_t drv, input cyl_t cyl);
		host_write(8'h0f);
		host_write({7'b0, drv});
		host_write(cyl);
	endtask

	task automatic wait_drive_idle(input int bit_pos);
		fdc_byte_t msr;
		host_read(1'b0, msr);
		while (msr[bit_pos])
			host_read(1'b0, msr);
	endtask

	task automatic sense_int(input fdc_byte_t exp_st0, input fdc_byte_t exp_pcn);
		fdc_byte_t val;
		host_write(8'h08);
		host_read(1'b1, val);
		check_byte(val, exp_st0, "SENSE INTERRUPT st0");
		host_read(1'b1, val);
		check_byte(val, exp_pcn, "SENSE INTERRUPT pcn");
	endtask

	task automatic drive_status(input fdc_byte_t sel, input fdc_byte_t exp);
		fdc_byte_t val;
		host_write(8'h04);
		host_write(sel);
		host_read(1'b1, val);
		check_byte(val, exp, "SENSE DRIVE STATUS");
	endtask

	// ==========================================================
	// directed tests
	// ==========================================================
	task automatic test_reset_state;
		fdc_byte_t val;
		host_read(1'b0, val);
		check_byte(val, 8'h80, "main status after reset");
		host_read(1'b1, val);
		check_byte(val, 8'hff, "data register in idle");
	endtask

	task automatic test_invalid_cmd;
		fdc_byte_t val;
		host_write(8'h00);
		host_read(1'b0, val);
		check_byte(val, 8'hd0, "main status after invalid byte"); // rqm, dio, cb
		host_read(1'b1, val);
		check_byte(val, 8'h80, "invalid command reply");
		host_read(1'b0, val);
		check_byte(val, 8'h80, "main status after invalid reply");
		host_write(8'h08);
		host_read(1'b1, val);
		check_byte(val, 8'h80, "SENSE INTERRUPT with nothing pending");
	endtask

	task automatic test_slow_seek;
		fdc_byte_t val;
		host_write(8'h03);
		host_write(8'hc1); // step rate 12
		host_write(8'h02);
		cyl0 = 8'(1 + {$random(seed)} % 39);
		seek(1'b0, cyl0);
		host_read(1'b0, val);
		assert (val[MSR_D0B]) else
			fail_run($sformatf("FAILED at %0t: drive 0 busy bit clear in main status %02h",
				$time, val));
		wait_drive_idle(MSR_D0B);
		sense_int(8'h20, cyl0);
	endtask

	task automatic test_fast_seek_recal;
		set_lines(2'b11, 2'b11, 2'b00, 1'b1);
		cyl1 = 8'(1 + {$random(seed)} % 39);
		seek(1'b1, cyl1);
		wait_drive_idle(MSR_D1B);
		sense_int(8'h21, cyl1);
		host_write(8'h07);
		host_write(8'h01);
		wait_drive_idle(MSR_D1B);
		sense_int(8'h21, 8'h00);
		set_lines(2'b11, 2'b11, 2'b00, 1'b0);
	endtask

	task automatic test_seek_errors;
		set_lines(2'b10, 2'b11, 2'b00, 1'b0); // drive 0 motor off
		seek(1'b0, 8'(1 + {$random(seed)} % 39));
		wait_drive_idle(MSR_D0B);
		sense_int(8'he8, cyl0);
		set_lines(2'b11, 2'b11, 2'b00, 1'b0);
		seek(1'b0, 8'(MAX_CYL + {$random(seed)} % 20)); // past the last track
		wait_drive_idle(MSR_D0B);
		sense_int(8'he8, cyl0);
	endtask

	// drive 0 sits on a nonzero cylinder, drive 1 was recalibrated
	task automatic test_drive_status;
		set_lines(2'b11, 2'b01, 2'b11, 1'b0);
		drive_status(8'h04, 8'h64); // ready, protected, head 1
		drive_status(8'h05, 8'h15); // not ready, track 0, head 1, drive 1
		host_write(8'h07);
		host_write(8'h00);
		wait_drive_idle(MSR_D0B);
		drive_status(8'h04, 8'h74); // now on track 0 as well
	endtask

	initial begin
		clk_sys   = 1'b0;
		reset     = 1'b1;
		nrd       = 1'b1;
		nwr       = 1'b1;
		a0        = 1'b0;
		fast      = 1'b0;
		din       = '0;
		motor     = 2'b11;
		ready     = 2'b11;
		wp        = 2'b00;
		seed      = 30659;
		cycle_cnt = 0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		test_reset_state();
		test_invalid_cmd();
		test_slow_seek();
		test_fast_seek_recal();
		test_seek_errors();
		test_drive_status();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hdl/fdc_pkg.sv
hdl/fdc_host_port.sv
hdl/fdc_cmd_seq.sv
hdl/fdc_head_stepper.sv
hdl/fdc_top.sv
tests/fdc_sva.sv
tests/fdc_tb.sv
